//--- filelist.f
+incdir+.
csr_pkg.sv
csr_access_check.sv
csr_counters.sv
csr_regfile.sv
csr_top.sv
csr_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module csr_tb -f filelist.f -o csr_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"

//--- csr_tb.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_tb import csr_pkg::*; ();
    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] MSTATUS_WMASK = 32'h007E_19AA;  // Implemented mstatus bits
    localparam logic [11:0] ADDR_LIST [0:25] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_STVEC,
        `CSR_ADDR_SSCRATCH, `CSR_ADDR_SEPC, `CSR_ADDR_SCAUSE, `CSR_ADDR_STVAL,
        `CSR_ADDR_SATP, `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH, `CSR_ADDR_INSTRET,
        `CSR_ADDR_INSTRETH, `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
        `CSR_ADDR_MHARTID, `CSR_ADDR_CURPRIV,
        12'h7C0, 12'h3A0, 12'h104, 12'hC00   // Not implemented
    };

    logic        clk;
    logic        rst_n;
    csr_req_t    req;
    logic        instret_incr;
    logic [31:0] rdata;
    logic        invalid;
    csr_ctrl_t   ctrl;

    logic [31:0] seed;
    logic [1:0]  m_priv;
    logic [31:0] m_mstatus;      // Kept in the architectural bit layout
    logic        m_misa_atomic;
    logic [31:0] m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic [31:0] m_stvec, m_sscratch, m_sepc, m_scause, m_stval, m_satp;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    csr_req_t    r;

    csr_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .instret_incr (instret_incr),
        .rdata        (rdata),
        .invalid      (invalid),
        .ctrl         (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick(input int n);
        return int'(lcg_next() >> 16) % n;   // Upper bits have the longer period
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic model_reset();
        m_priv        = 2'd3;
        m_mstatus     = 32'h0;
        m_misa_atomic = 1'b0;
        {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = 160'h0;
        {m_stvec, m_sscratch, m_sepc, m_scause, m_stval, m_satp} = 192'h0;
        m_cycle   = 64'h0;
        m_instret = 64'h0;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] a, output logic known);
        known = 1'b1;
        case (a)
            `CSR_ADDR_MSTATUS:   return m_mstatus;
            `CSR_ADDR_MISA:      return `CSR_MISA_BASE | {31'h0, m_misa_atomic};
            `CSR_ADDR_MTVEC:     return m_mtvec;
            `CSR_ADDR_MSCRATCH:  return m_mscratch;
            `CSR_ADDR_MEPC:      return m_mepc;
            `CSR_ADDR_MCAUSE:    return m_mcause;
            `CSR_ADDR_MTVAL:     return m_mtval;
            `CSR_ADDR_STVEC:     return m_stvec;
            `CSR_ADDR_SSCRATCH:  return m_sscratch;
            `CSR_ADDR_SEPC:      return m_sepc;
            `CSR_ADDR_SCAUSE:    return m_scause;
            `CSR_ADDR_STVAL:     return m_stval;
            `CSR_ADDR_SATP:      return m_satp;
            `CSR_ADDR_CYCLE:     return m_cycle[31:0];
            `CSR_ADDR_CYCLEH:    return m_cycle[63:32];
            `CSR_ADDR_INSTRET:   return m_instret[31:0];
            `CSR_ADDR_INSTRETH:  return m_instret[63:32];
            `CSR_ADDR_MVENDORID: return `CSR_MVENDORID_VAL;
            `CSR_ADDR_MARCHID:   return `CSR_MARCHID_VAL;
            `CSR_ADDR_MIMPID:    return `CSR_MIMPID_VAL;
            `CSR_ADDR_MHARTID:   return `CSR_MHARTID_VAL;
            `CSR_ADDR_CURPRIV:   return {30'h0, m_priv};
            default: begin
                known = 1'b0;
                return 32'h0;
            end
        endcase
    endfunction

    function automatic logic model_illegal(input csr_req_t q, input logic known,
                                           output logic rd, output logic wr);
        rd = q.cmd inside {CSR_READ, CSR_READ_WRITE, CSR_READ_SET, CSR_READ_CLEAR};
        wr = (q.cmd inside {CSR_WRITE, CSR_READ_WRITE}) ||
             ((q.cmd inside {CSR_READ_SET, CSR_READ_CLEAR}) && q.wdata != 32'h0);
        return (rd || wr) && (m_priv < q.addr[9:8] || (wr && q.addr[11:10] == 2'b11) || !known);
    endfunction

    // Advance the model by one clock edge under request q
    task automatic model_commit(input csr_req_t q, input logic incr);
        logic [31:0] old;
        logic [31:0] nv;
        logic [63:0] cyc_next;
        logic [63:0] ins_next;
        logic        known;
        logic        rd;
        logic        wr;
        logic        bad;
        old = model_read(q.addr, known);
        bad = model_illegal(q, known, rd, wr);
        case (q.cmd)
            CSR_READ_SET:   nv = old | q.wdata;
            CSR_READ_CLEAR: nv = old & ~q.wdata;
            default:        nv = q.wdata;
        endcase
        cyc_next = m_cycle + 64'd1;
        ins_next = m_instret + {63'd0, incr};
        if (q.cmd == CSR_EXC_BEGIN) begin
            m_mepc            = q.exc_epc;
            m_mcause          = q.exc_cause;
            m_mstatus[12:11]  = m_priv;
            m_mstatus[7]      = m_mstatus[3];   // mpie takes mie
            m_mstatus[3]      = 1'b0;
            m_priv            = 2'd3;
        end else if (q.cmd == CSR_MRET && m_priv == 2'd3) begin
            m_priv            = m_mstatus[12:11];
            m_mstatus[3]      = m_mstatus[7];
            m_mstatus[7]      = 1'b1;
            m_mstatus[12:11]  = 2'd0;
        end else if (wr && !bad) begin
            case (q.addr)
                `CSR_ADDR_MSTATUS: begin
                    if (nv[12:11] == 2'b10)
                        nv[12:11] = m_mstatus[12:11];   // Reserved mpp keeps the old mode
                    m_mstatus = nv & MSTATUS_WMASK;
                end
                `CSR_ADDR_MISA:      m_misa_atomic = nv[0];
                `CSR_ADDR_MTVEC:     if (nv[1:0] == 2'b00) m_mtvec = nv;
                `CSR_ADDR_MSCRATCH:  m_mscratch = nv;
                `CSR_ADDR_MEPC:      if (nv[1:0] == 2'b00) m_mepc = nv;
                `CSR_ADDR_MCAUSE:    m_mcause = nv;
                `CSR_ADDR_MTVAL:     m_mtval = nv;
                `CSR_ADDR_STVEC:     if (nv[1:0] == 2'b00) m_stvec = nv;
                `CSR_ADDR_SSCRATCH:  m_sscratch = nv;
                `CSR_ADDR_SEPC:      if (nv[1:0] == 2'b00) m_sepc = nv;
                `CSR_ADDR_SCAUSE:    m_scause = nv;
                `CSR_ADDR_STVAL:     m_stval = nv;
                `CSR_ADDR_SATP:      m_satp = nv & 32'h803F_FFFF;   // MODE and PPN only
                `CSR_ADDR_CYCLE:     cyc_next[31:0] = nv;
                `CSR_ADDR_CYCLEH:    cyc_next[63:32] = nv;
                `CSR_ADDR_INSTRET:   ins_next[31:0] = nv;
                `CSR_ADDR_INSTRETH:  ins_next[63:32] = nv;
                default:             ;
            endcase
        end
        m_cycle   = cyc_next;
        m_instret = ins_next;
    endtask

    task automatic check_outputs();
        logic [31:0] old;
        logic        known;
        logic        rd;
        logic        wr;
        logic        bad;
        old = model_read(req.addr, known);
        bad = model_illegal(req, known, rd, wr);
        compare("rdata", rdata, (rd && !bad) ? old : 32'h0);
        compare("invalid", invalid, bad || (req.cmd == CSR_MRET && m_priv != 2'd3));
        compare("ctrl.priv", ctrl.priv, m_priv);
        compare("ctrl.mstatus", ctrl.mstatus, {m_mstatus[22:17], m_mstatus[12:11],
                m_mstatus[8:7], m_mstatus[5], m_mstatus[3], m_mstatus[1]});
        compare("ctrl.mtvec", ctrl.mtvec, m_mtvec);
        compare("ctrl.stvec", ctrl.stvec, m_stvec);
        compare("ctrl.mepc", ctrl.mepc, m_mepc);
        compare("ctrl.sepc", ctrl.sepc, m_sepc);
        compare("ctrl.satp", {ctrl.satp_mode, ctrl.satp_ppn}, {m_satp[31], m_satp[21:0]});
    endtask

    // One cycle: commit the pending request, drive the next one, check mid-cycle
    task automatic step(input csr_req_t q, input logic incr);
        @(posedge clk);
        model_commit(req, instret_incr);
        req          <= q;
        instret_incr <= incr;
        @(negedge clk);
        check_outputs();
    endtask

    function automatic csr_req_t make_req(input csr_cmd_e cmd, input logic [11:0] addr,
                                          input logic [31:0] wdata);
        return '{cmd: cmd, addr: addr, wdata: wdata, exc_cause: 32'h0, exc_epc: 32'h0};
    endfunction

    function automatic logic [31:0] random_wdata();
        case (pick(6))
            0:       return 32'h0;                        // Set and clear become reads
            1:       return 32'hFFFF_FFF0 | pick(16);     // Near counter wrap
            2:       return rand32() & ~32'h3;            // Aligned vector
            3:       return (pick(4) << 11) | 32'h88;     // Any mpp with mie and mpie
            default: return rand32();
        endcase
    endfunction

    // Mode 0 any command, 1 CSR accesses only, 2 counter accesses only
    function automatic csr_req_t random_req(input int mode);
        csr_req_t q;
        int       k;
        k           = (mode == 0) ? pick(8) : 1 + pick(5);
        q.cmd       = csr_cmd_e'(k[3:0]);
        q.addr      = (mode == 2) ? ADDR_LIST[13 + pick(4)] : ADDR_LIST[pick(26)];
        q.wdata     = random_wdata();
        q.exc_cause = rand32();
        q.exc_epc   = rand32();
        return q;
    endfunction

    task automatic expect_read(input logic [11:0] addr, input logic [31:0] value);
        step(make_req(CSR_READ, addr, 32'h0), 1'b0);
        compare("rdata", rdata, value);
    endtask

    // Trap into M, set mpp, return, then wait for ctrl to show the new mode
    task automatic enter_priv(input logic [1:0] target);
        int waited;
        step(make_req(CSR_EXC_BEGIN, 12'h0, 32'h0), 1'b0);
        step(make_req(CSR_WRITE, `CSR_ADDR_MSTATUS, {19'h0, target, 11'h0}), 1'b0);
        step(make_req(CSR_MRET, 12'h0, 32'h0), 1'b0);
        waited = 0;
        while (ctrl.priv != target) begin
            if (waited == 4) begin
                $display("Timeout: privilege did not change to mode %0d after MRET", target);
                abort_run();
            end
            step(make_req(CSR_NONE, 12'h0, 32'h0), 1'b0);
            waited++;
        end
    endtask

    initial begin
        int n;
        for (n = 0; n < MAX_CYCLES; n++)
            @(posedge clk);
        $display("Timeout: simulation ran past %0d cycles without finishing", MAX_CYCLES);
        abort_run();
    end

    initial begin
        int i;
        seed         = 32'd30;
        rst_n        = 1'b0;
        req          = '0;
        instret_incr = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            model_reset();
        end
        rst_n <= 1'b1;

        step(make_req(CSR_NONE, 12'h0, 32'h0), 1'b0);
        compare("ctrl.priv", ctrl.priv, 2'd3);
        compare("ctrl.mstatus", ctrl.mstatus, 13'h0);
        compare("ctrl.mtvec", ctrl.mtvec, 32'h0);
        expect_read(`CSR_ADDR_MVENDORID, `CSR_MVENDORID_VAL);
        expect_read(`CSR_ADDR_MARCHID, `CSR_MARCHID_VAL);
        expect_read(`CSR_ADDR_MIMPID, `CSR_MIMPID_VAL);
        expect_read(`CSR_ADDR_MHARTID, `CSR_MHARTID_VAL);
        expect_read(`CSR_ADDR_MISA, `CSR_MISA_BASE);
        expect_read(`CSR_ADDR_CURPRIV, 32'd3);

        for (i = 0; i < 600; i++)
            step(random_req(1), pick(2) == 1);   // Machine mode accesses

        step(make_req(CSR_WRITE, `CSR_ADDR_MHARTID, 32'h1), 1'b0);
        compare("invalid", invalid, 1'b1);
        step(make_req(CSR_READ, 12'h7C0, 32'h0), 1'b0);
        compare("invalid", invalid, 1'b1);
        enter_priv(2'd0);
        step(make_req(CSR_READ, `CSR_ADDR_MSCRATCH, 32'h0), 1'b0);
        compare("invalid", invalid, 1'b1);
        step(make_req(CSR_MRET, 12'h0, 32'h0), 1'b0);
        compare("invalid", invalid, 1'b1);
        for (i = 0; i < 150; i++)
            step(random_req(1), pick(2) == 1);
        enter_priv(2'd1);
        step(make_req(CSR_WRITE, `CSR_ADDR_MTVEC, 32'h100), 1'b0);
        compare("invalid", invalid, 1'b1);
        for (i = 0; i < 150; i++)
            step(random_req(1), pick(2) == 1);

        step(make_req(CSR_EXC_BEGIN, 12'h0, 32'h0), 1'b0);
        step(make_req(CSR_WRITE, `CSR_ADDR_MSTATUS, 32'h0000_0880), 1'b0);  // mpp S, mpie set
        step(make_req(CSR_MRET, 12'h0, 32'h0), 1'b0);
        r           = make_req(CSR_EXC_BEGIN, 12'h0, 32'h0);
        r.exc_epc   = 32'h0000_2468;
        r.exc_cause = 32'd13;
        step(r, 1'b0);
        compare("ctrl.priv", ctrl.priv, 2'd1);
        compare("ctrl.mstatus.mie", ctrl.mstatus.mie, 1'b1);
        step(make_req(CSR_MRET, 12'h0, 32'h0), 1'b0);
        compare("ctrl.mepc", ctrl.mepc, 32'h0000_2468);
        compare("ctrl.priv", ctrl.priv, 2'd3);
        compare("ctrl.mstatus.mpp", ctrl.mstatus.mpp, 2'd1);
        compare("ctrl.mstatus.mie", ctrl.mstatus.mie, 1'b0);
        step(make_req(CSR_NONE, 12'h0, 32'h0), 1'b0);
        compare("ctrl.priv", ctrl.priv, 2'd1);
        compare("ctrl.mstatus.mpp", ctrl.mstatus.mpp, 2'd0);
        compare("ctrl.mstatus.mie", ctrl.mstatus.mie, 1'b1);

        step(make_req(CSR_EXC_BEGIN, 12'h0, 32'h0), 1'b0);   // Counters are machine mode only
        for (i = 0; i < 500; i++)
            step(random_req(2), pick(2) == 1);   // Counter halves only
        for (i = 0; i < 3000; i++)
            step(random_req(0), pick(2) == 1);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- csr_top.sv
`timescale 1ns/1ps

module csr_top import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_req_t    req,
    input  logic        instret_incr,
    output logic [31:0] rdata,
    output logic        invalid,
    output csr_ctrl_t   ctrl
);
    csr_verdict_t verdict;
    logic         addr_known;
    logic         wdata_zero;
    logic [3:0]   cnt_wr;
    logic [31:0]  cnt_wdata;
    logic [63:0]  cycle64;
    logic [63:0]  instret64;

    assign wdata_zero = req.wdata == 32'h0;  // Set or clear with no bits is a read
    assign invalid    = verdict.invalid;

    csr_access_check u_check (
        .cmd        (req.cmd),
        .addr       (req.addr),
        .wdata_zero (wdata_zero),
        .priv       (ctrl.priv),
        .addr_known (addr_known),
        .verdict    (verdict)
    );

    csr_counters u_cnt (
        .clk          (clk),
        .rst_n        (rst_n),
        .instret_incr (instret_incr),
        .cnt_wr       (cnt_wr),
        .cnt_wdata    (cnt_wdata),
        .cycle64      (cycle64),
        .instret64    (instret64)
    );

    csr_regfile u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .verdict    (verdict),
        .cycle64    (cycle64),
        .instret64  (instret64),
        .addr_known (addr_known),
        .cnt_wr     (cnt_wr),
        .cnt_wdata  (cnt_wdata),
        .rdata      (rdata),
        .ctrl       (ctrl)
    );

endmodule

//--- csr_regfile.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regfile import csr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_req_t     req,
    input  csr_verdict_t verdict,
    input  logic [63:0]  cycle64,
    input  logic [63:0]  instret64,
    output logic         addr_known,
    output logic [3:0]   cnt_wr,
    output logic [31:0]  cnt_wdata,
    output logic [31:0]  rdata,
    output csr_ctrl_t    ctrl
);
    priv_e       priv;
    mstatus_t    mstatus;
    logic        misa_atomic;   // Lets M-mode software emulate atomics
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] stvec;
    logic [31:0] sscratch;
    logic [31:0] sepc;
    logic [31:0] scause;
    logic [31:0] stval;
    logic        satp_mode;
    logic [21:0] satp_ppn;
    logic [31:0] mstatus_img;
    logic [31:0] old_val;
    logic [31:0] new_val;

    assign mstatus_img = {9'h0, mstatus.tsr, mstatus.tw, mstatus.tvm,
                          mstatus.mxr, mstatus.sum, mstatus.mprv, 4'h0,
                          mstatus.mpp, 2'h0, mstatus.spp, mstatus.mpie, 1'b0,
                          mstatus.spie, 1'b0, mstatus.mie, 1'b0, mstatus.sie, 1'b0};

    // Address map and old value
    always_comb begin
        addr_known = 1'b1;
        case (req.addr)
            `CSR_ADDR_MSTATUS:   old_val = mstatus_img;
            `CSR_ADDR_MISA:      old_val = `CSR_MISA_BASE | {31'd0, misa_atomic};
            `CSR_ADDR_MTVEC:     old_val = mtvec;
            `CSR_ADDR_MSCRATCH:  old_val = mscratch;
            `CSR_ADDR_MEPC:      old_val = mepc;
            `CSR_ADDR_MCAUSE:    old_val = mcause;
            `CSR_ADDR_MTVAL:     old_val = mtval;
            `CSR_ADDR_STVEC:     old_val = stvec;
            `CSR_ADDR_SSCRATCH:  old_val = sscratch;
            `CSR_ADDR_SEPC:      old_val = sepc;
            `CSR_ADDR_SCAUSE:    old_val = scause;
            `CSR_ADDR_STVAL:     old_val = stval;
            `CSR_ADDR_SATP:      old_val = {satp_mode, 9'h0, satp_ppn};
            `CSR_ADDR_CYCLE:     old_val = cycle64[31:0];
            `CSR_ADDR_CYCLEH:    old_val = cycle64[63:32];
            `CSR_ADDR_INSTRET:   old_val = instret64[31:0];
            `CSR_ADDR_INSTRETH:  old_val = instret64[63:32];
            `CSR_ADDR_MVENDORID: old_val = `CSR_MVENDORID_VAL;
            `CSR_ADDR_MARCHID:   old_val = `CSR_MARCHID_VAL;
            `CSR_ADDR_MIMPID:    old_val = `CSR_MIMPID_VAL;
            `CSR_ADDR_MHARTID:   old_val = `CSR_MHARTID_VAL;
            `CSR_ADDR_CURPRIV:   old_val = {30'h0, priv};
            default: begin
                addr_known = 1'b0;
                old_val    = 32'h0;
            end
        endcase
    end

    always_comb begin
        case (req.cmd)
            CSR_WRITE, CSR_READ_WRITE: new_val = req.wdata;
            CSR_READ_SET:              new_val = old_val | req.wdata;
            CSR_READ_CLEAR:            new_val = old_val & ~req.wdata;
            default:                   new_val = old_val;
        endcase
    end

    // Counter halves live in csr_counters
    always_comb begin
        cnt_wr = 4'b0000;
        if (verdict.do_write) begin
            case (req.addr)
                `CSR_ADDR_CYCLE:    cnt_wr = 4'b0001;
                `CSR_ADDR_CYCLEH:   cnt_wr = 4'b0010;
                `CSR_ADDR_INSTRET:  cnt_wr = 4'b0100;
                `CSR_ADDR_INSTRETH: cnt_wr = 4'b1000;
                default:            cnt_wr = 4'b0000;
            endcase
        end
    end

    assign cnt_wdata = new_val;
    assign rdata     = verdict.do_read ? old_val : 32'h0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv        <= PRIV_M;
            mstatus     <= '0;
            misa_atomic <= 1'b0;
            mtvec       <= `CSR_REG_RESET;
            mscratch    <= `CSR_REG_RESET;
            mepc        <= `CSR_REG_RESET;
            mcause      <= `CSR_REG_RESET;
            mtval       <= `CSR_REG_RESET;
            stvec       <= `CSR_REG_RESET;
            sscratch    <= `CSR_REG_RESET;
            sepc        <= `CSR_REG_RESET;
            scause      <= `CSR_REG_RESET;
            stval       <= `CSR_REG_RESET;
            satp_mode   <= 1'b0;
            satp_ppn    <= 22'h0;
        end else if (req.cmd == CSR_EXC_BEGIN) begin
            mepc         <= req.exc_epc;
            mcause       <= req.exc_cause;
            mstatus.mpp  <= priv;           // Save the trapped mode
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            priv         <= PRIV_M;
        end else if (req.cmd == CSR_MRET && !verdict.invalid) begin
            priv         <= priv_e'(mstatus.mpp);
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= PRIV_U;
        end else if (verdict.do_write) begin
            case (req.addr)
                `CSR_ADDR_MSTATUS: begin
                    mstatus.tsr  <= new_val[22];
                    mstatus.tw   <= new_val[21];
                    mstatus.tvm  <= new_val[20];
                    mstatus.mxr  <= new_val[19];
                    mstatus.sum  <= new_val[18];
                    mstatus.mprv <= new_val[17];
                    if (new_val[12:11] != 2'b10)    // Reserved mode is not stored
                        mstatus.mpp <= new_val[12:11];
                    mstatus.spp  <= new_val[8];
                    mstatus.mpie <= new_val[7];
                    mstatus.spie <= new_val[5];
                    mstatus.mie  <= new_val[3];
                    mstatus.sie  <= new_val[1];
                end
                `CSR_ADDR_MISA:     misa_atomic <= new_val[0];
                `CSR_ADDR_MTVEC:    if (new_val[1:0] == 2'b00) mtvec <= new_val;
                `CSR_ADDR_MSCRATCH: mscratch <= new_val;
                `CSR_ADDR_MEPC:     if (new_val[1:0] == 2'b00) mepc <= new_val;
                `CSR_ADDR_MCAUSE:   mcause <= new_val;
                `CSR_ADDR_MTVAL:    mtval <= new_val;
                `CSR_ADDR_STVEC:    if (new_val[1:0] == 2'b00) stvec <= new_val;
                `CSR_ADDR_SSCRATCH: sscratch <= new_val;
                `CSR_ADDR_SEPC:     if (new_val[1:0] == 2'b00) sepc <= new_val;
                `CSR_ADDR_SCAUSE:   scause <= new_val;
                `CSR_ADDR_STVAL:    stval <= new_val;
                `CSR_ADDR_SATP: begin
                    satp_mode <= new_val[31];
                    satp_ppn  <= new_val[21:0];
                end
                default:            mscratch <= mscratch;  // Counters or read-only
            endcase
        end
    end

    assign ctrl = '{priv: priv, mstatus: mstatus, mtvec: mtvec, stvec: stvec,
                    mepc: mepc, sepc: sepc, satp_mode: satp_mode, satp_ppn: satp_ppn};

    // Trap entry and MRET only ever load a legal mode
    assert property (@(posedge clk) disable iff (!rst_n) priv != 2'b10)
        else $error("current privilege holds reserved value 2");

endmodule

//--- csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instret_incr,
    input  logic [3:0]  cnt_wr,     // cycle, cycleh, instret, instreth
    input  logic [31:0] cnt_wdata,
    output logic [63:0] cycle64,
    output logic [63:0] instret64
);
    logic [63:0] cycle_inc;
    logic [63:0] instret_inc;

    assign cycle_inc   = cycle64 + 64'd1;                    // Carry runs into the high half
    assign instret_inc = instret64 + {63'd0, instret_incr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle64   <= 64'd0;
            instret64 <= 64'd0;
        end else begin
            cycle64[31:0]    <= cnt_wr[0] ? cnt_wdata : cycle_inc[31:0];
            cycle64[63:32]   <= cnt_wr[1] ? cnt_wdata : cycle_inc[63:32];
            instret64[31:0]  <= cnt_wr[2] ? cnt_wdata : instret_inc[31:0];
            instret64[63:32] <= cnt_wr[3] ? cnt_wdata : instret_inc[63:32];
        end
    end

    // The register file selects at most one half per command
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cnt_wr))
        else $error("cnt_wr selects more than one counter half");

endmodule

//--- csr_access_check.sv
`timescale 1ns/1ps

module csr_access_check import csr_pkg::*; (
    input  csr_cmd_e     cmd,
    input  logic [11:0]  addr,
    input  logic         wdata_zero,
    input  priv_e        priv,
    input  logic         addr_known,
    output csr_verdict_t verdict
);
    logic is_read;
    logic is_write;
    logic priv_low;
    logic is_ro;
    logic mret_bad;
    logic access_bad;

    always_comb begin
        is_read  = 1'b0;
        is_write = 1'b0;
        case (cmd)
            CSR_READ:       is_read = 1'b1;
            CSR_WRITE:      is_write = 1'b1;
            CSR_READ_WRITE: begin
                is_read  = 1'b1;
                is_write = 1'b1;
            end
            CSR_READ_SET, CSR_READ_CLEAR: begin
                is_read  = 1'b1;
                is_write = !wdata_zero;  // Zero mask is only a read
            end
            default:        is_read = 1'b0;
        endcase
    end

    assign priv_low   = priv < addr[9:8];       // Bits 9:8 give the lowest privilege
    assign is_ro      = addr[11:10] == 2'b11;
    assign mret_bad   = (cmd == CSR_MRET) && (priv != PRIV_M);
    assign access_bad = (is_read || is_write) &&
                        (priv_low || (is_write && is_ro) || !addr_known);

    assign verdict = '{invalid:  access_bad || mret_bad,
                       do_write: is_write && !access_bad,
                       do_read:  is_read && !access_bad,
                       is_ro:    is_ro};

    // A commit never reaches a read-only or rejected address
    always_comb begin
        assert (!(verdict.do_write && (verdict.invalid || verdict.is_ro)))
            else $error("CSR write committed on an illegal access");
    end

endmodule

//--- csr_pkg.sv
package csr_pkg;

    typedef enum logic [3:0] {
        CSR_NONE       = 4'd0,
        CSR_READ       = 4'd1,
        CSR_WRITE      = 4'd2,
        CSR_READ_WRITE = 4'd3,
        CSR_READ_SET   = 4'd4,
        CSR_READ_CLEAR = 4'd5,
        CSR_MRET       = 4'd6,
        CSR_EXC_BEGIN  = 4'd7
    } csr_cmd_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] exc_cause;
        logic [31:0] exc_epc;    // PC of the faulting instruction
    } csr_req_t;

    typedef struct packed {
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] mpp;
        logic       spp;
        logic       mpie;
        logic       spie;
        logic       mie;
        logic       sie;
    } mstatus_t;

    typedef struct packed {
        priv_e       priv;
        mstatus_t    mstatus;
        logic [31:0] mtvec;
        logic [31:0] stvec;
        logic [31:0] mepc;
        logic [31:0] sepc;
        logic        satp_mode;
        logic [21:0] satp_ppn;
    } csr_ctrl_t;

    typedef struct packed {
        logic invalid;
        logic do_write;
        logic do_read;
        logic is_ro;
    } csr_verdict_t;

endpackage

//--- csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine mode registers
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343

// Supervisor mode registers
`define CSR_ADDR_STVEC     12'h105
`define CSR_ADDR_SSCRATCH  12'h140
`define CSR_ADDR_SEPC      12'h141
`define CSR_ADDR_SCAUSE    12'h142
`define CSR_ADDR_STVAL     12'h143
`define CSR_ADDR_SATP      12'h180

`define CSR_ADDR_CYCLE     12'hB00
`define CSR_ADDR_CYCLEH    12'hB80
`define CSR_ADDR_INSTRET   12'hB02
`define CSR_ADDR_INSTRETH  12'hB82

`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12
`define CSR_ADDR_MIMPID    12'hF13
`define CSR_ADDR_MHARTID   12'hF14
`define CSR_ADDR_CURPRIV   12'hFC0  // Custom, reads current privilege

`define CSR_MVENDORID_VAL  32'h0000_0000  // Non-commercial implementation
`define CSR_MARCHID_VAL    32'h0000_0001
`define CSR_MIMPID_VAL     32'h0000_0001
`define CSR_MHARTID_VAL    32'h0000_0000
`define CSR_MISA_BASE      32'h4014_1100  // MXL=1, U, S, M and I
`define CSR_REG_RESET      32'h0000_0000

`endif
